// File: verification/display_shift_input.txt
# gap state  score d2 d1 d0  record d3 d2 d1 d0  expected glyph 7 down to 0
# gap is the number of cycles before the next line is applied
3 0    0 0 0   0 0 0 0   0  0  0  0  0  0  0  0
3 1    0 0 0   0 0 0 0   10 0  0  0  0  0  0  0
3 5    0 0 0   0 0 0 0   10 0  0  0  0  0  0  4
3 8    0 0 0   0 0 0 0   10 0  0  0  0  0  0  7
3 9    0 0 0   0 0 0 0   10 0  0  0  0  13 14 0
3 12   0 0 0   0 0 0 0   10 0  0  0  0  13 14 3
3 16   0 0 0   0 0 0 0   10 0  0  0  0  13 14 7
3 17   0 0 0   0 0 0 0   10 0  0  15 16 17 18 0
3 21   0 0 0   0 0 0 0   10 0  0  15 16 17 18 4
3 24   0 0 0   0 0 0 0   10 0  0  15 16 17 18 7
3 25   0 0 0   0 0 0 0   11 0  0  0  0  0  0  0
3 32   0 0 0   0 0 0 0   11 0  0  0  0  0  0  7
3 33   0 0 0   0 0 0 0   11 0  0  0  1  0  0  0
3 38   0 0 0   0 0 0 0   11 0  0  0  1  0  0  5
3 41   0 0 0   0 0 0 0   11 0  0  0  2  0  0  0
3 48   0 0 0   0 0 0 0   11 0  0  0  2  0  0  7
3 49   0 0 0   9 8 7 6   12 0  0  9  8  7  6  0
3 49   0 0 0   1 2 3 4   12 0  0  1  2  3  4  0
3 50   3 4 5   0 0 0 0   12 0  0  21 3  4  5  0
3 54   9 9 9   0 0 0 0   12 0  0  21 9  9  9  0
3 54   1 0 0   0 0 0 0   12 0  0  21 1  0  0  0
3 55   7 2 5   0 0 0 0   12 0  0  22 7  2  5  0
3 62   0 5 0   0 0 0 0   12 0  0  19 0  5  0  0
3 65   8 8 1   0 0 0 0   12 0  0  10 8  8  1  0
3 69   4 0 2   0 0 0 0   12 0  0  10 4  0  2  0
3 70   0 0 0   0 0 0 0   20 23 21 14 20 22 0  0
3 71   0 0 0   0 0 0 0   11 22 0  0  0  0  0  0
3 72   0 0 0   0 0 0 0   20 22 0  0  0  0  0  0
3 73   0 0 0   0 0 0 0   20 22 0  0  0  0  0  0
3 127  0 0 0   0 0 0 0   20 22 0  0  0  0  0  0
3 60   6 6 6   0 0 0 0   12 0  0  19 6  6  6  0
3 100  3 2 1   0 0 0 0   12 0  0  19 3  2  1  0
3 3    0 0 0   0 0 0 0   10 0  0  0  0  0  0  2
1 20   2 4 6   5 0 0 7   10 0  0  15 16 17 18 3
1 44   2 4 6   5 0 0 7   11 0  0  0  2  0  0  3
1 49   2 4 6   5 0 0 7   12 0  0  5  0  0  7  0
1 57   2 4 6   5 0 0 7   12 0  0  22 2  4  6  0
1 71   2 4 6   5 0 0 7   11 22 0  0  0  0  0  0
1 0    2 4 6   5 0 0 7   0  0  0  0  0  0  0  0
1 10   2 4 6   5 0 0 7   10 0  0  0  0  13 14 1
1 90   2 4 6   5 0 0 7   10 0  0  0  0  13 14 1
3 28   2 4 6   5 0 0 7   11 0  0  0  0  0  0  3

// File: display_shift.f
src/display_pkg.sv
src/screen_if.sv
src/screen_decoder.sv
src/text_rom.sv
src/digit_overlay.sv
src/display_shift_top.sv
verification/display_shift_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = display_shift_tb
FILELIST = display_shift.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: verification/display_shift_tb.sv
`timescale 1ns/1ps

module display_shift_tb;
    import display_pkg::*;

    localparam int    CLK_PERIOD = 4;
    localparam int    MAX_VEC    = 256;
    localparam string INPUT_FILE = "verification/display_shift_input.txt";

    logic       clk;
    logic       rst;
    state_idx_t state;
    glyph_t     score_in [0:2];
    glyph_t     rec_in   [0:3];
    glyph_t     disp_out [0:7];

    int         vec_gap   [MAX_VEC];  // Cycles until the next vector
    state_idx_t vec_state [MAX_VEC];
    glyph_t     vec_score [MAX_VEC][0:2];
    glyph_t     vec_rec   [MAX_VEC][0:3];
    glyph_t     vec_exp   [MAX_VEC][0:7];
    glyph_t     zero_row  [0:7] = '{default: '0};
    int         n_vec     = 0;
    int         n_checked = 0;
    logic       loaded    = 1'b0;
    int         pending [$];
    int         due     [$];

    display_shift_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .score_d2 (score_in[2]),
        .score_d1 (score_in[1]),
        .score_d0 (score_in[0]),
        .rec_d3   (rec_in[3]),
        .rec_d2   (rec_in[2]),
        .rec_d1   (rec_in[1]),
        .rec_d0   (rec_in[0]),
        .disp_7   (disp_out[7]),
        .disp_6   (disp_out[6]),
        .disp_5   (disp_out[5]),
        .disp_4   (disp_out[4]),
        .disp_3   (disp_out[3]),
        .disp_2   (disp_out[2]),
        .disp_1   (disp_out[1]),
        .disp_0   (disp_out[0])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic stop_failed();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input glyph_t actual, input glyph_t expected, input string what);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, what, actual, expected);
            stop_failed();
        end
    endtask

    task automatic check_row(input glyph_t exp_row [0:7], input string tag);
        for (int p = 0; p < 8; p++) begin
            check_value(disp_out[p], exp_row[p], $sformatf("%s, position %0d", tag, p));
        end
    endtask

    task automatic apply_vector(input int i);
        state <= vec_state[i];
        for (int k = 0; k < 3; k++) begin
            score_in[k] <= vec_score[i][k];
        end
        for (int k = 0; k < 4; k++) begin
            rec_in[k] <= vec_rec[i][k];
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    cnt;
        int    f [17];
        string line;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", INPUT_FILE);
            stop_failed();
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.getc(0) == "#") continue;  // Column notes
                cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                              f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (cnt <= 0) continue;
                if (cnt != 17 || n_vec >= MAX_VEC) begin
                    $display("Bad or excess line in %s: %s", INPUT_FILE, line);
                    stop_failed();
                end else begin
                    vec_gap[n_vec]   = f[0];
                    vec_state[n_vec] = state_idx_t'(f[1]);
                    for (int k = 0; k < 3; k++) begin
                        vec_score[n_vec][2-k] = glyph_t'(f[2+k]);
                    end
                    for (int k = 0; k < 4; k++) begin
                        vec_rec[n_vec][3-k] = glyph_t'(f[5+k]);
                    end
                    for (int k = 0; k < 8; k++) begin
                        vec_exp[n_vec][7-k] = glyph_t'(f[9+k]);  // Leftmost first in file
                    end
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        wait (loaded);
        repeat (n_vec * 3 + 50) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", n_vec * 3 + 50);
        stop_failed();
    end

    ////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////
    initial begin
        int idx;
        int cyc;
        int next_apply;
        int cur;
        rst   = 1'b1;
        state = '0;
        for (int k = 0; k < 3; k++) begin
            score_in[k] = '0;
        end
        for (int k = 0; k < 4; k++) begin
            rec_in[k] = '0;
        end
        load_vectors();
        loaded = 1'b1;

        @(posedge clk);
        @(negedge clk);
        check_row(zero_row, "in reset");
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_row(zero_row, "in reset");

        idx        = 0;
        cyc        = 0;
        next_apply = 0;
        while (idx < n_vec || due.size() > 0) begin
            @(posedge clk);
            if (idx < n_vec && cyc == next_apply) begin
                apply_vector(idx);
                pending.push_back(idx);
                due.push_back(cyc + 2);  // Decoder then overlay
                next_apply = cyc + vec_gap[idx];
                idx++;
            end
            @(negedge clk);
            if (due.size() > 0 && due[0] == cyc) begin
                cur = pending.pop_front();
                void'(due.pop_front());
                check_row(vec_exp[cur], $sformatf("vector %0d state %0d", cur, vec_state[cur]));
                n_checked++;
            end else if (cyc < 2) begin
                check_row(zero_row, "first screen after reset");
            end
            cyc++;
        end

        if (n_vec > 0 && n_checked == n_vec) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("No vectors were checked from %s", INPUT_FILE);
            stop_failed();
        end
    end

endmodule

// File: src/display_shift_top.sv
`timescale 1ns/1ps

module display_shift_top (
    input  logic                    clk,
    input  logic                    rst,
    input  display_pkg::state_idx_t state,
    input  display_pkg::glyph_t     score_d2,
    input  display_pkg::glyph_t     score_d1,
    input  display_pkg::glyph_t     score_d0,
    input  display_pkg::glyph_t     rec_d3,
    input  display_pkg::glyph_t     rec_d2,
    input  display_pkg::glyph_t     rec_d1,
    input  display_pkg::glyph_t     rec_d0,
    output display_pkg::glyph_t     disp_7,
    output display_pkg::glyph_t     disp_6,
    output display_pkg::glyph_t     disp_5,
    output display_pkg::glyph_t     disp_4,
    output display_pkg::glyph_t     disp_3,
    output display_pkg::glyph_t     disp_2,
    output display_pkg::glyph_t     disp_1,
    output display_pkg::glyph_t     disp_0
);
    import display_pkg::*;

    glyph_row_t text_row;
    glyph_row_t disp_row;

    screen_if scr ();

    screen_decoder i_decoder (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .scr   (scr.decoder)
    );

    text_rom i_text_rom (
        .scr  (scr.datapath),
        .text (text_row)
    );

    digit_overlay i_overlay (
        .clk      (clk),
        .rst      (rst),
        .scr      (scr.datapath),
        .text     (text_row),
        .score_d2 (score_d2),
        .score_d1 (score_d1),
        .score_d0 (score_d0),
        .rec_d3   (rec_d3),
        .rec_d2   (rec_d2),
        .rec_d1   (rec_d1),
        .rec_d0   (rec_d0),
        .disp     (disp_row)
    );

    // Leftmost position first
    assign disp_7 = disp_row[7];
    assign disp_6 = disp_row[6];
    assign disp_5 = disp_row[5];
    assign disp_4 = disp_row[4];
    assign disp_3 = disp_row[3];
    assign disp_2 = disp_row[2];
    assign disp_1 = disp_row[1];
    assign disp_0 = disp_row[0];

endmodule

// File: src/digit_overlay.sv
`timescale 1ns/1ps

module digit_overlay (
    input  logic                    clk,
    input  logic                    rst,
    screen_if.datapath              scr,
    input  display_pkg::glyph_row_t text,
    input  display_pkg::glyph_t     score_d2,
    input  display_pkg::glyph_t     score_d1,
    input  display_pkg::glyph_t     score_d0,
    input  display_pkg::glyph_t     rec_d3,
    input  display_pkg::glyph_t     rec_d2,
    input  display_pkg::glyph_t     rec_d1,
    input  display_pkg::glyph_t     rec_d0,
    output display_pkg::glyph_row_t disp
);
    import display_pkg::*;

    glyph_row_t merged;
    logic       inputs_ok;
    logic       disp_ok;

    ////////////////////////////////////////////////////////////
    // Live digits over the fixed text
    ////////////////////////////////////////////////////////////
    always_comb begin
        merged = text;
        case (scr.kind)
            KIND_FREE_PLAIN, KIND_FREE_LO, KIND_FREE_HIGH: begin
                merged[0] = digit_glyph(scr.level);
            end
            KIND_AUTO_SONG: begin
                merged[3] = digit_glyph(scr.song_hi);
                merged[0] = digit_glyph(scr.song_lo);
            end
            KIND_STUDY_GRADE: begin
                merged[3] = score_d2;
                merged[2] = score_d1;
                merged[1] = score_d0;
            end
            KIND_STUDY_RECORD: begin
                merged[4] = rec_d3;
                merged[3] = rec_d2;
                merged[2] = rec_d1;
                merged[1] = rec_d0;
            end
            default: begin
                merged = text;  // Text only
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp <= '0;
        end else begin
            disp <= merged;
        end
    end

    // Range checks on the score and record inputs and on the registered row
    always_comb begin
        inputs_ok = (score_d2 <= GLYPH_MAX) && (score_d1 <= GLYPH_MAX) &&
                    (score_d0 <= GLYPH_MAX) && (rec_d3 <= GLYPH_MAX) &&
                    (rec_d2 <= GLYPH_MAX) && (rec_d1 <= GLYPH_MAX) &&
                    (rec_d0 <= GLYPH_MAX);
        disp_ok = 1'b1;
        for (int i = 0; i < DISP_POSITIONS; i++) begin
            if (disp[i] > GLYPH_MAX) begin
                disp_ok = 1'b0;
            end
        end
    end

    a_glyph_range : assert property (@(posedge clk) disable iff (rst)
        inputs_ok |=> disp_ok);

endmodule

// File: src/text_rom.sv
`timescale 1ns/1ps

module text_rom (
    screen_if.datapath               scr,
    output display_pkg::glyph_row_t  text
);
    import display_pkg::*;

    glyph_t grade_letter;

    always_comb begin
        case (scr.grade)
            3'd0:    grade_letter = GLYPH_C_LC;
            3'd1:    grade_letter = GLYPH_D_LC;
            3'd2:    grade_letter = GLYPH_E;
            default: grade_letter = GLYPH_F;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Fixed letters per screen kind
    ////////////////////////////////////////////////////////////
    always_comb begin
        text = {DISP_POSITIONS{GLYPH_BLANK}};
        case (scr.kind)
            KIND_FREE_PLAIN: begin
                text[7] = GLYPH_F;
            end
            KIND_FREE_LO: begin
                text[7] = GLYPH_F;
                text[2] = GLYPH_L_LC;
                text[1] = GLYPH_O_LC;
            end
            KIND_FREE_HIGH: begin
                text[7] = GLYPH_F;
                text[4] = GLYPH_H;
                text[3] = GLYPH_I_LC;
                text[2] = GLYPH_G_LC;
                text[1] = GLYPH_H_LC;
            end
            KIND_AUTO_SONG: begin
                text[7] = GLYPH_A;
            end
            KIND_STUDY_RECORD: begin
                text[7] = GLYPH_S;
            end
            KIND_STUDY_GRADE: begin
                text[7] = GLYPH_S;
                text[4] = grade_letter;
            end
            KIND_BANNER_RECORD: begin
                text[7] = GLYPH_R_LC;
                text[6] = GLYPH_E_LC;
                text[5] = GLYPH_C_LC;
                text[4] = GLYPH_O_LC;
                text[3] = GLYPH_R_LC;
                text[2] = GLYPH_D_LC;
            end
            KIND_BANNER_AD: begin
                text[7] = GLYPH_A;
                text[6] = GLYPH_D_LC;
            end
            KIND_BANNER_RD: begin
                text[7] = GLYPH_R_LC;
                text[6] = GLYPH_D_LC;
            end
            default: begin
                text = {DISP_POSITIONS{GLYPH_BLANK}};  // Blank screen
            end
        endcase
    end

endmodule

// File: src/screen_decoder.sv
`timescale 1ns/1ps

module screen_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  display_pkg::state_idx_t state,
    screen_if.decoder               scr
);
    import display_pkg::*;

    state_idx_t   offset;
    screen_kind_t kind_d;
    num3_t        level_d;
    num3_t        song_hi_d;
    num3_t        song_lo_d;
    num3_t        grade_d;
    logic         in_range;

    assign in_range = (state <= STATE_LAST);

    ////////////////////////////////////////////////////////////
    // Range compare, highest range first
    ////////////////////////////////////////////////////////////
    always_comb begin
        kind_d    = KIND_BLANK;
        level_d   = '0;
        song_hi_d = '0;
        song_lo_d = '0;
        grade_d   = '0;
        offset    = '0;
        if (state >= STATE_BANNER_RD) begin
            kind_d = KIND_BANNER_RD;  // Above last is masked by in_range
        end else if (state == STATE_BANNER_AD) begin
            kind_d = KIND_BANNER_AD;
        end else if (state == STATE_BANNER_RECORD) begin
            kind_d = KIND_BANNER_RECORD;
        end else if (state >= STATE_STUDY_GRADE) begin
            kind_d = KIND_STUDY_GRADE;
            offset = state - STATE_STUDY_GRADE;
            // Five states per grade letter
            if (offset < 7'd5) begin
                grade_d = 3'd0;
            end else if (offset < 7'd10) begin
                grade_d = 3'd1;
            end else if (offset < 7'd15) begin
                grade_d = 3'd2;
            end else begin
                grade_d = 3'd3;
            end
        end else if (state == STATE_STUDY_RECORD) begin
            kind_d = KIND_STUDY_RECORD;
        end else if (state >= STATE_AUTO_SONG) begin
            kind_d    = KIND_AUTO_SONG;
            offset    = state - STATE_AUTO_SONG;
            song_hi_d = offset[5:3];  // n / 8
            song_lo_d = offset[2:0];  // n % 8
        end else if (state >= STATE_FREE_HIGH) begin
            kind_d  = KIND_FREE_HIGH;
            offset  = state - STATE_FREE_HIGH;
            level_d = offset[2:0];
        end else if (state >= STATE_FREE_LO) begin
            kind_d  = KIND_FREE_LO;
            offset  = state - STATE_FREE_LO;
            level_d = offset[2:0];
        end else if (state >= STATE_FREE_PLAIN) begin
            kind_d  = KIND_FREE_PLAIN;
            offset  = state - STATE_FREE_PLAIN;
            level_d = offset[2:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Screen register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            scr.kind    <= KIND_BLANK;
            scr.level   <= '0;
            scr.song_hi <= '0;
            scr.song_lo <= '0;
            scr.grade   <= '0;
        end else if (in_range) begin  // Unknown index keeps last screen
            scr.kind    <= kind_d;
            scr.level   <= level_d;
            scr.song_hi <= song_hi_d;
            scr.song_lo <= song_lo_d;
            scr.grade   <= grade_d;
        end
    end

    // Tens digit and grade index the text tables downstream
    a_field_range : assert property (@(posedge clk) disable iff (rst)
        (scr.song_hi < 3'd3) && (scr.grade < 3'd4));

endmodule

// File: src/screen_if.sv
`timescale 1ns/1ps

interface screen_if;
    import display_pkg::*;

    screen_kind_t kind;
    num3_t        level;    // Free-play level digit
    num3_t        song_hi;  // Song tens digit
    num3_t        song_lo;  // Song ones digit
    num3_t        grade;    // 0..3 maps to c d E F

    modport decoder (
        output kind,
        output level,
        output song_hi,
        output song_lo,
        output grade
    );

    modport datapath (
        input kind,
        input level,
        input song_hi,
        input song_lo,
        input grade
    );

endinterface

// File: src/display_pkg.sv
package display_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and vector types
    ////////////////////////////////////////////////////////////
    localparam int GLYPH_W        = 6;
    localparam int STATE_W        = 7;
    localparam int NUM3_W         = 3;
    localparam int DISP_POSITIONS = 8;

    typedef logic [GLYPH_W-1:0]                     glyph_t;
    typedef logic [STATE_W-1:0]                     state_idx_t;
    typedef logic [NUM3_W-1:0]                      num3_t;
    typedef logic [DISP_POSITIONS-1:0][GLYPH_W-1:0] glyph_row_t;  // [7] is leftmost

    ////////////////////////////////////////////////////////////
    // Glyph codes
    ////////////////////////////////////////////////////////////
    localparam glyph_t GLYPH_0 = 6'd0;
    localparam glyph_t GLYPH_1 = 6'd1;
    localparam glyph_t GLYPH_2 = 6'd2;
    localparam glyph_t GLYPH_3 = 6'd3;
    localparam glyph_t GLYPH_4 = 6'd4;
    localparam glyph_t GLYPH_5 = 6'd5;
    localparam glyph_t GLYPH_6 = 6'd6;
    localparam glyph_t GLYPH_7 = 6'd7;
    localparam glyph_t GLYPH_8 = 6'd8;
    localparam glyph_t GLYPH_9 = 6'd9;

    localparam glyph_t GLYPH_F    = 6'd10;
    localparam glyph_t GLYPH_A    = 6'd11;
    localparam glyph_t GLYPH_S    = 6'd12;
    localparam glyph_t GLYPH_L_LC = 6'd13;
    localparam glyph_t GLYPH_O_LC = 6'd14;
    localparam glyph_t GLYPH_H    = 6'd15;
    localparam glyph_t GLYPH_I_LC = 6'd16;
    localparam glyph_t GLYPH_G_LC = 6'd17;
    localparam glyph_t GLYPH_H_LC = 6'd18;
    localparam glyph_t GLYPH_E    = 6'd19;
    localparam glyph_t GLYPH_R_LC = 6'd20;
    localparam glyph_t GLYPH_C_LC = 6'd21;
    localparam glyph_t GLYPH_D_LC = 6'd22;
    localparam glyph_t GLYPH_E_LC = 6'd23;

    localparam glyph_t GLYPH_MAX   = GLYPH_E_LC;
    localparam glyph_t GLYPH_BLANK = GLYPH_0;  // Unlit shares the zero code

    ////////////////////////////////////////////////////////////
    // State index map
    ////////////////////////////////////////////////////////////
    localparam state_idx_t STATE_BLANK         = 7'd0;
    localparam state_idx_t STATE_FREE_PLAIN    = 7'd1;
    localparam state_idx_t STATE_FREE_LO       = 7'd9;
    localparam state_idx_t STATE_FREE_HIGH     = 7'd17;
    localparam state_idx_t STATE_AUTO_SONG     = 7'd25;
    localparam state_idx_t STATE_STUDY_RECORD  = 7'd49;
    localparam state_idx_t STATE_STUDY_GRADE   = 7'd50;
    localparam state_idx_t STATE_BANNER_RECORD = 7'd70;
    localparam state_idx_t STATE_BANNER_AD     = 7'd71;
    localparam state_idx_t STATE_BANNER_RD     = 7'd72;
    localparam state_idx_t STATE_LAST          = STATE_BANNER_RD;

    typedef enum logic [3:0] {
        KIND_BLANK,
        KIND_FREE_PLAIN,
        KIND_FREE_LO,
        KIND_FREE_HIGH,
        KIND_AUTO_SONG,
        KIND_STUDY_RECORD,
        KIND_STUDY_GRADE,
        KIND_BANNER_RECORD,
        KIND_BANNER_AD,
        KIND_BANNER_RD
    } screen_kind_t;

    // Small number to its digit glyph
    function automatic glyph_t digit_glyph(input num3_t n);
        return glyph_t'(n);
    endfunction

endpackage
